// ==== hdl/mul_macros.svh ====
// widths and step counts of the multiply unit, included by its packages and RTL files
`ifndef MUL_MACROS_SVH
`define MUL_MACROS_SVH

// operand and product widths
`define DATA_WIDTH 32
`define PP_LEN 34
`define PROD_WIDTH 64

// booth array size
`define PP_CNT 17

// carry-save folding schedule
`define PP_PER_STEP 4
`define STEP_CNT 5

`endif

// ==== hdl/mul_types_pkg.sv ====
// request, result and operation types seen at the multiply unit boundary, imported by RTL
`include "mul_macros.svh"

package mul_types_pkg;

  // same order as the low funct3 bits of the m-extension multiplies
  typedef enum logic [1:0] {
    op_mul    = 2'd0,
    op_mulh   = 2'd1,
    op_mulhsu = 2'd2,
    op_mulhu  = 2'd3
  } mul_op_e;

  typedef struct packed {
    mul_op_e                op;
    logic [`DATA_WIDTH-1:0] src1;
    logic [`DATA_WIDTH-1:0] src2;
  } mul_req_t;

  typedef struct packed {
    logic [`DATA_WIDTH-1:0] data;
  } mul_result_t;

endpackage

// ==== hdl/booth_pkg.sv ====
// partial-product and carry-save types of the multiply datapath, imported by its RTL
`include "mul_macros.svh"

package booth_pkg;

  // each entry already shifted to 2*i, negate carry of the previous entry folded in
  typedef logic [`PP_CNT-1:0][`PROD_WIDTH-1:0] pp_array_t;

  // redundant product, value is sum + carry
  typedef struct packed {
    logic [`PROD_WIDTH-1:0] sum;
    logic [`PROD_WIDTH-1:0] carry;
  } csa_pair_t;

  typedef logic [$clog2(`STEP_CNT)-1:0] step_idx_t;

endpackage

// ==== hdl/mul_booth_code.sv ====
// radix-4 booth encoder, turns two sources and their sign control into placed partial products
`include "mul_macros.svh"

module mul_booth_code (
  input  logic [1:0]             sign,
  input  logic [`DATA_WIDTH-1:0] src1,
  input  logic [`DATA_WIDTH-1:0] src2,
  output booth_pkg::pp_array_t   pp
);

  localparam int DW     = `DATA_WIDTH;
  localparam int LEN    = `PP_LEN;
  localparam int PW     = `PROD_WIDTH;
  localparam int PP_CNT = `PP_CNT;

  logic [LEN-1:0]    x;
  logic [LEN-1:0]    x2;
  logic [LEN-1:0]    y_ext;
  logic [LEN:0]      y;
  logic [PP_CNT-2:0] c;

  // two extra bits keep the unsigned case positive
  assign x     = {{(LEN - DW){sign[0] & src1[DW-1]}}, src1};
  assign y_ext = {{(LEN - DW){sign[1] & src2[DW-1]}}, src2};
  assign x2    = {x[LEN-2:0], 1'b0};

  // implicit zero below bit 0 of the multiplier
  assign y = {y_ext, 1'b0};

  for (genvar i = 0; i < PP_CNT; i++) begin : g_pp
    logic [2:0]     trip;
    logic [LEN-1:0] prod;
    logic [PW-1:0]  placed;

    assign trip = y[2*i +: 3];

    // negative multiples are one's complement here, the +1 rides in c
    always_comb begin
      prod = '0;
      case (trip)
        3'b001, 3'b010: prod = x;
        3'b011:         prod = x2;
        3'b100:         prod = ~x2;
        3'b101, 3'b110: prod = ~x;
        default:        prod = '0;
      endcase
    end

    assign placed = {{(PW - LEN){prod[LEN-1]}}, prod} << (2 * i);

    // last triplet is never negative, its carry is dropped
    if (i < PP_CNT - 1) begin : g_neg
      assign c[i] = trip[2] & ~(trip[1] & trip[0]);
    end

    // carry of the previous product lands two bits below this one
    if (i == 0) begin : g_first
      assign pp[i] = placed;
    end else begin : g_rest
      assign pp[i] = placed | (PW'(c[i-1]) << (2 * i - 2));
    end
  end

endmodule

// ==== hdl/mul_csa_accum.sv ====
// carry-save accumulator folding one group of booth products per cycle into a sum/carry pair
`include "mul_macros.svh"

module mul_csa_accum (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 accum_clear,
  input  logic                 accum_en,
  input  booth_pkg::step_idx_t step,
  input  booth_pkg::pp_array_t pp,
  output booth_pkg::csa_pair_t acc
);

  import booth_pkg::*;

  localparam int PW     = `PROD_WIDTH;
  localparam int GRP    = `PP_PER_STEP;
  localparam int PP_CNT = `PP_CNT;

  logic [GRP-1:0][PW-1:0] grp;
  csa_pair_t              lvl [GRP+1];

  // 3:2 compressor over the full product width
  function automatic csa_pair_t csa3(input logic [PW-1:0] a,
                                     input logic [PW-1:0] b,
                                     input logic [PW-1:0] c);
    csa_pair_t    r;
    logic [PW-1:0] maj;
    maj     = (a & b) | (a & c) | (b & c);
    r.sum   = a ^ b ^ c;
    r.carry = {maj[PW-2:0], 1'b0};
    return r;
  endfunction

  // products past the end of the array count as zero
  always_comb begin
    logic [4:0] idx;
    for (int k = 0; k < GRP; k++) begin
      idx    = 5'(int'(step) * GRP + k);
      grp[k] = (int'(idx) < PP_CNT) ? pp[idx] : '0;
    end
  end

  // chain of four compressor levels, one product each
  always_comb begin
    lvl[0] = acc;
    for (int k = 0; k < GRP; k++) begin
      lvl[k+1] = csa3(lvl[k].sum, lvl[k].carry, grp[k]);
    end
  end

  always_ff @(posedge clock) begin
    if (reset || accum_clear) begin
      acc <= '0;
    end else if (accum_en) begin
      acc <= lvl[GRP];
    end
  end

endmodule

// ==== hdl/mul_step_counter.sv ====
// group index counter stepping the accumulator through the booth products
`include "mul_macros.svh"

module mul_step_counter (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 clear,
  input  logic                 advance,
  output booth_pkg::step_idx_t step,
  output logic                 last
);

  always_ff @(posedge clock) begin
    if (reset || clear) begin
      step <= '0;
    end else if (advance) begin
      step <= step + 1'b1;
    end
  end

  // final group holds only the top product
  assign last = (step == $bits(step)'(`STEP_CNT - 1));

endmodule

// ==== hdl/mul_ctrl_fsm.sv ====
// multiply control FSM, latches a request and sequences counter, accumulator and result
module mul_ctrl_fsm (
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    start,
  input  mul_types_pkg::mul_req_t req,
  input  logic                    last,
  output logic                    busy,
  output logic                    clear,
  output logic                    advance,
  output logic                    accum_clear,
  output logic                    accum_en,
  output logic                    finish,
  output mul_types_pkg::mul_req_t held_req,
  output logic [1:0]              sign
);

  import mul_types_pkg::*;

  typedef enum logic [1:0] {
    st_idle,
    st_accum,
    st_finish
  } state_t;

  state_t state;
  logic   start_ok;

  // busy still high in the done cycle, so a start there is dropped too
  assign start_ok = start && (state == st_idle) && !busy;

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= st_idle;
      busy  <= 1'b0;
    end else begin
      case (state)
        st_idle:   if (start_ok) state <= st_accum;
        st_accum:  if (last) state <= st_finish;
        st_finish: state <= st_idle;
        default:   state <= st_idle;
      endcase
      if (start_ok) begin
        busy <= 1'b1;
      end else if (state == st_idle) begin
        busy <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (start_ok) begin
      held_req <= req;
    end
  end

  assign clear       = start_ok;
  assign accum_clear = start_ok;
  assign accum_en    = (state == st_accum);
  assign advance     = (state == st_accum);
  assign finish      = (state == st_finish);

  // bit 0 for src1, bit 1 for src2
  always_comb begin
    case (held_req.op)
      op_mulh:   sign = 2'b11;
      op_mulhsu: sign = 2'b01;
      default:   sign = 2'b00;
    endcase
  end

endmodule

// ==== hdl/mul_result_sel.sv ====
// final carry-propagate add and word select, registers the result with a one-cycle done
`include "mul_macros.svh"

module mul_result_sel (
  input  logic                       clock,
  input  logic                       reset,
  input  logic                       finish,
  input  mul_types_pkg::mul_op_e     op,
  input  booth_pkg::csa_pair_t       acc,
  output logic                       done,
  output mul_types_pkg::mul_result_t result
);

  import mul_types_pkg::*;

  localparam int DW = `DATA_WIDTH;
  localparam int PW = `PROD_WIDTH;

  logic [PW-1:0] product;

  assign product = acc.sum + acc.carry;

  always_ff @(posedge clock) begin
    if (reset) begin
      done <= 1'b0;
    end else begin
      done <= finish;
    end
  end

  // held until the next finish
  always_ff @(posedge clock) begin
    if (finish) begin
      result.data <= (op == op_mul) ? product[DW-1:0] : product[PW-1:DW];
    end
  end

endmodule

// ==== hdl/mul_top.sv ====
// multiply unit of the execute stage, start/busy/done strobes around a booth carry-save datapath
module mul_top (
  input  logic                       clock,
  input  logic                       reset,
  input  logic                       start,
  input  mul_types_pkg::mul_req_t    req,
  output logic                       busy,
  output logic                       done,
  output mul_types_pkg::mul_result_t result
);

  import mul_types_pkg::*;
  import booth_pkg::*;

  mul_req_t  held_req;
  logic [1:0] sign;
  logic      clear;
  logic      advance;
  logic      accum_clear;
  logic      accum_en;
  logic      finish;
  logic      last;
  step_idx_t step;
  pp_array_t pp;
  csa_pair_t acc;

  mul_ctrl_fsm u_ctrl (
    .clock       (clock),
    .reset       (reset),
    .start       (start),
    .req         (req),
    .last        (last),
    .busy        (busy),
    .clear       (clear),
    .advance     (advance),
    .accum_clear (accum_clear),
    .accum_en    (accum_en),
    .finish      (finish),
    .held_req    (held_req),
    .sign        (sign)
  );

  mul_step_counter u_step (
    .clock   (clock),
    .reset   (reset),
    .clear   (clear),
    .advance (advance),
    .step    (step),
    .last    (last)
  );

  mul_booth_code u_booth (
    .sign (sign),
    .src1 (held_req.src1),
    .src2 (held_req.src2),
    .pp   (pp)
  );

  mul_csa_accum u_accum (
    .clock       (clock),
    .reset       (reset),
    .accum_clear (accum_clear),
    .accum_en    (accum_en),
    .step        (step),
    .pp          (pp),
    .acc         (acc)
  );

  mul_result_sel u_result (
    .clock  (clock),
    .reset  (reset),
    .finish (finish),
    .op     (held_req.op),
    .acc    (acc),
    .done   (done),
    .result (result)
  );

endmodule

// ==== sim/mul_tb_asserts.sv ====
// concurrent checks on the start, busy and done strobes, bound into the multiply unit top
module mul_tb_asserts (
  input logic clock,
  input logic reset,
  input logic start,
  input logic busy,
  input logic done
);

  done_one_cycle: assert property (@(posedge clock) disable iff (reset) done |=> !done)
    else $error("done stayed high for more than one cycle");

  // done closes a busy span
  done_after_busy: assert property (@(posedge clock) disable iff (reset) done |-> $past(busy))
    else $error("done without busy in the cycle before");

  busy_from_start: assert property (@(posedge clock) disable iff (reset)
    $rose(busy) |-> $past(start))
    else $error("busy rose without a start in idle");

endmodule

bind mul_top mul_tb_asserts u_asserts (
  .clock (clock),
  .reset (reset),
  .start (start),
  .busy  (busy),
  .done  (done)
);

// ==== sim/mul_tb.sv ====
// testbench for the multiply unit, random and corner operands checked against a reference model
`include "mul_macros.svh"

module mul_tb;

  import mul_types_pkg::*;

  localparam int CLK_PERIOD   = 8;
  localparam int RESET_CYCLES = 16;
  localparam int LATENCY      = 6;
  localparam int OP_TIMEOUT   = 20;
  localparam int IDLE_CYCLES  = 10;
  localparam int CORNER_OPS   = 100;
  localparam int RANDOM_OPS   = 200;
  localparam int TIMING_OPS   = 4;
  localparam int IGNORE_OPS   = 2;
  // one extra slot covers the idle check
  localparam int NUM_OPS      = CORNER_OPS + RANDOM_OPS + TIMING_OPS + IGNORE_OPS + 1;
  localparam int WATCHDOG_TIME = NUM_OPS * 10 * CLK_PERIOD + RESET_CYCLES * CLK_PERIOD;

  typedef struct packed {
    mul_req_t    req;
    mul_result_t res;
    logic [31:0] start_edge;
  } pend_t;

  logic        clock;
  logic        reset;
  logic        start;
  mul_req_t    req;
  logic        busy;
  logic        done;
  mul_result_t result;

  logic [31:0] lfsr_state;
  int          cycle_cnt = 0;
  int          err_cnt = 0;
  int          chk_cnt = 0;
  pend_t       pending[$];

  mul_top UUT (
    .clock  (clock),
    .reset  (reset),
    .start  (start),
    .req    (req),
    .busy   (busy),
    .done   (done),
    .result (result)
  );

  initial begin
    clock = 1'b0;
    forever #(CLK_PERIOD / 2) clock = ~clock;
  end

  always @(posedge clock) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  // taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      val = {val[30:0], lfsr_state[0]};
    end
  endtask

  // mulh signs both, mulhsu only src1, mul and mulhu none
  function automatic mul_result_t ref_mul(input mul_op_e op, input logic [31:0] a,
                                          input logic [31:0] b);
    logic [63:0] ea;
    logic [63:0] eb;
    logic [63:0] prod;
    logic        a_signed;
    logic        b_signed;
    mul_result_t r;
    a_signed = (op == op_mulh) || (op == op_mulhsu);
    b_signed = (op == op_mulh);
    ea = a_signed ? {{32{a[31]}}, a} : {32'b0, a};
    eb = b_signed ? {{32{b[31]}}, b} : {32'b0, b};
    prod = ea * eb;
    r.data = (op == op_mul) ? prod[31:0] : prod[63:32];
    return r;
  endfunction

  task automatic check_result(input string what, input mul_result_t got, input mul_result_t exp);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("ERR %0t: %s result %h, expected %h", $time, what, got.data, exp.data);
    end
  endtask

  task automatic check_busy(input string what, input logic got, input logic exp);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_latency(input string what, input int got, input int exp);
    chk_cnt++;
    if (got != exp) begin
      err_cnt++;
      $display("ERR %0t: %s took %0d cycles, expected %0d", $time, what, got, exp);
    end
  endtask

  // compares every done against the oldest outstanding request
  always @(negedge clock) begin
    pend_t p;
    if (!reset && done) begin
      if (pending.size() == 0) begin
        err_cnt++;
        $display("done was raised at time %0t while no request was outstanding", $time);
      end else begin
        p = pending.pop_front();
        check_result($sformatf("%s %h %h", p.req.op.name(), p.req.src1, p.req.src2),
                     result, p.res);
        check_latency("start to done", cycle_cnt - int'(p.start_edge), LATENCY);
      end
    end
  end

  task automatic run_op(input mul_op_e op, input logic [31:0] a, input logic [31:0] b,
                        input bit intrude);
    pend_t p;
    int    waited;
    bit    seen;
    @(negedge clock);
    req.op   = op;
    req.src1 = a;
    req.src2 = b;
    start    = 1'b1;
    p.req        = req;
    p.res        = ref_mul(op, a, b);
    p.start_edge = cycle_cnt + 1;
    pending.push_back(p);
    @(negedge clock);
    start    = 1'b0;
    req.src1 = ~a;
    req.src2 = ~b;
    waited   = 0;
    seen     = 1'b0;
    while (!seen && waited < OP_TIMEOUT) begin
      check_busy("busy during operation", busy, 1'b1);
      if (done) begin
        seen = 1'b1;
      end else begin
        // second request while busy must be dropped
        start = intrude && (waited == 1);
        @(negedge clock);
        waited++;
      end
    end
    start = 1'b0;
    if (!seen) begin
      err_cnt++;
      $display("no done within %0d cycles of a %s start", OP_TIMEOUT, op.name());
    end
    @(negedge clock);
    check_busy("busy after done", busy, 1'b0);
    check_busy("done after done", done, 1'b0);
  endtask

  task automatic report_test(input string name, input int errs_before);
    $display("test %-16s %s, %0d errors", name, (err_cnt == errs_before) ? "ok" : "FAILED",
             err_cnt - errs_before);
  endtask

  initial begin
    logic [31:0] corners[5];
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] bits;
    int          base;
    start      = 1'b0;
    req        = '0;
    reset      = 1'b1;
    lfsr_state = 32'd46;
    corners    = '{32'h0, 32'h1, 32'hffff_ffff, 32'h8000_0000, 32'h7fff_ffff};
    repeat (RESET_CYCLES) @(negedge clock);
    reset = 1'b0;

    base = err_cnt;
    repeat (IDLE_CYCLES) begin
      @(negedge clock);
      check_busy("busy before first start", busy, 1'b0);
      check_busy("done before first start", done, 1'b0);
    end
    report_test("idle after reset", base);

    base = err_cnt;
    for (int o = 0; o < 4; o++) begin
      for (int i = 0; i < 5; i++) begin
        for (int j = 0; j < 5; j++) begin
          run_op(mul_op_e'(o), corners[i], corners[j], 1'b0);
        end
      end
    end
    report_test("corner operands", base);

    base = err_cnt;
    repeat (RANDOM_OPS) begin
      take_bits(2, bits);
      take_bits(32, a);
      take_bits(32, b);
      run_op(mul_op_e'(bits[1:0]), a, b, 1'b0);
    end
    report_test("random operands", base);

    base = err_cnt;
    for (int o = 0; o < TIMING_OPS; o++) begin
      take_bits(32, a);
      take_bits(32, b);
      run_op(mul_op_e'(o), a, b, 1'b0);
    end
    report_test("done timing", base);

    base = err_cnt;
    take_bits(32, a);
    take_bits(32, b);
    run_op(op_mulhsu, a, b, 1'b1);
    // the unit must take a normal start right after
    run_op(op_mul, b, a, 1'b0);
    report_test("start while busy", base);

    if (pending.size() != 0) begin
      err_cnt++;
      $display("%0d requests never got a done", pending.size());
    end
    $display("%0d checks, %0d errors", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_TIME);
    $display("watchdog expired after %0d time units, the run did not complete", WATCHDOG_TIME);
    $display("Verification failed");
    $finish;
  end

endmodule

// ==== sources.f ====
+incdir+hdl
hdl/mul_types_pkg.sv
hdl/booth_pkg.sv
hdl/mul_booth_code.sv
hdl/mul_csa_accum.sv
hdl/mul_step_counter.sv
hdl/mul_ctrl_fsm.sv
hdl/mul_result_sel.sv
hdl/mul_top.sv
sim/mul_tb_asserts.sv
sim/mul_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the multiply unit testbench with Verilator, runs it and checks the log
set -eo pipefail

cd "$(dirname "$0")"

verilator --binary --assert --top-module mul_tb -f sources.f -o mul_sim

./obj_dir/mul_sim | tee sim.log

if grep -q "Verification failed" sim.log; then
  echo "simulation reported failure"
  exit 1
fi

echo "simulation finished without failure"
